// File: flist.f
hdl/cnn_pkg.sv
hdl/cnn_fifo_other.sv
hdl/concat_sequencer.sv
hdl/cnn_concat_2in.sv
tests/cnn_concat_checker.sv
tests/cnn_concat_tb.sv

// File: Makefile
# Verilator build for the concat stage testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cnn_concat_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = SIMULATION FAILED
PASS_MSG  = SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# The log decides the verdict, a missing pass line also counts as failure
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/cnn_concat_tb.sv
`timescale 1ns/1ps

module cnn_concat_tb;

  //////////////////////////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_TESTS      = 6;
  localparam int FRAME_TOTAL    = cnn_pkg::FRAME_PIXELS_1 + cnn_pkg::FRAME_PIXELS_2;
  // Four cycles per pixel is generous for any write order
  localparam int TIMEOUT_CYCLES = NUM_TESTS * FRAME_TOTAL * 4 + 100;
  // Room for a few stray pixels past the expected total
  localparam int GOT_DEPTH      = NUM_TESTS * FRAME_TOTAL + 16;

  // How the two producers interleave their writes
  typedef enum int {
    MODE_B1_FIRST,
    MODE_B2_FIRST,
    MODE_ALTERNATE,
    MODE_RANDOM
  } mode_t;

  // One row per frame, applied back to back without reset
  string test_name [NUM_TESTS] = '{
    "b1_first", "b2_first", "alternate", "random_gaps", "back_to_back", "random_wrap"
  };
  mode_t test_mode [NUM_TESTS] = '{
    MODE_B1_FIRST, MODE_B2_FIRST, MODE_ALTERNATE, MODE_RANDOM, MODE_ALTERNATE, MODE_RANDOM
  };
  // Pixel k of a branch is base plus k
  cnn_pkg::pixel_t test_base_no1 [NUM_TESTS] = '{
    16'h1000, 16'h3100, 16'h5300, 16'h7500, 16'ha700, 16'hfff8
  };
  cnn_pkg::pixel_t test_base_no2 [NUM_TESTS] = '{
    16'h2000, 16'h4200, 16'h6400, 16'h8600, 16'hb800, 16'h0ffa
  };

  //////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////

  logic            clk;
  logic            reset;
  logic            valid_in_no1;
  cnn_pkg::pixel_t in_no1;
  logic            valid_in_no2;
  cnn_pkg::pixel_t in_no2;
  cnn_pkg::pixel_t out;
  logic            valid_out;
  logic            frame_done;

  // Output capture, filled by the monitor
  cnn_pkg::pixel_t got_mem [GOT_DEPTH];
  int              got_count   = 0;
  int              frames_done = 0;

  // Branch 1 writes driven so far in the current frame
  int              writes_no1  = 0;
  int              cur_row     = 0;
  int              cycle_count = 0;
  integer          seed        = 32'h59d4;

  cnn_concat_2in UUT (
    .clk         (clk),
    .reset       (reset),
    .valid_in_no1(valid_in_no1),
    .in_no1      (in_no1),
    .valid_in_no2(valid_in_no2),
    .in_no2      (in_no2),
    .out         (out),
    .valid_out   (valid_out),
    .frame_done  (frame_done)
  );

  // 10 ns period
  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_pixel(
    input string           name,
    input cnn_pkg::pixel_t expected,
    input cnn_pkg::pixel_t actual
  );
    if (expected !== actual) begin
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (expected != actual) begin
      stop_run($sformatf("Fail %s pixel count: expected %0d, actual %0d",
                         name, expected, actual));
    end
  endtask

  // Concat rule, all of branch 1 then all of branch 2
  function automatic cnn_pkg::pixel_t expected_pixel(input int row, input int k);
    if (k < cnn_pkg::FRAME_PIXELS_1) begin
      return cnn_pkg::pixel_t'(test_base_no1[row] + k);
    end
    return cnn_pkg::pixel_t'(test_base_no2[row] + (k - cnn_pkg::FRAME_PIXELS_1));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Producers
  //////////////////////////////////////////////////////////////////////

  // One frame of writes on both branches, order set by the row's mode
  task automatic drive_row(input int row);
    int     n1;
    int     n2;
    logic   w1;
    logic   w2;
    logic   turn;
    integer r;
    n1   = 0;
    n2   = 0;
    turn = 1'b0;
    while (n1 < cnn_pkg::FRAME_PIXELS_1 || n2 < cnn_pkg::FRAME_PIXELS_2) begin
      @(posedge clk);
      w1 = 1'b0;
      w2 = 1'b0;
      case (test_mode[row])
        MODE_B1_FIRST: begin
          w1 = (n1 < cnn_pkg::FRAME_PIXELS_1);
          w2 = (n1 >= cnn_pkg::FRAME_PIXELS_1) && (n2 < cnn_pkg::FRAME_PIXELS_2);
        end
        MODE_B2_FIRST: begin
          w2 = (n2 < cnn_pkg::FRAME_PIXELS_2);
          w1 = (n2 >= cnn_pkg::FRAME_PIXELS_2) && (n1 < cnn_pkg::FRAME_PIXELS_1);
        end
        // One branch per cycle, the other takes over once one is done
        MODE_ALTERNATE: begin
          w1 = (n1 < cnn_pkg::FRAME_PIXELS_1) && (!turn || n2 >= cnn_pkg::FRAME_PIXELS_2);
          w2 = (n2 < cnn_pkg::FRAME_PIXELS_2) && (turn || n1 >= cnn_pkg::FRAME_PIXELS_1);
        end
        // Both, one or neither, idle cycles are the gaps
        MODE_RANDOM: begin
          r  = $random(seed);
          w1 = r[0] && (n1 < cnn_pkg::FRAME_PIXELS_1);
          w2 = r[1] && (n2 < cnn_pkg::FRAME_PIXELS_2);
        end
        default: begin
          w1 = 1'b0;
        end
      endcase
      valid_in_no1 <= w1;
      in_no1       <= cnn_pkg::pixel_t'(test_base_no1[row] + n1);
      valid_in_no2 <= w2;
      in_no2       <= cnn_pkg::pixel_t'(test_base_no2[row] + n2);
      if (w1) begin
        n1 = n1 + 1;
      end
      if (w2) begin
        n2 = n2 + 1;
      end
      writes_no1 <= n1;
      turn = ~turn;
    end
    @(posedge clk);
    valid_in_no1 <= 1'b0;
    valid_in_no2 <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor and timeout
  //////////////////////////////////////////////////////////////////////

  // Samples the previous cycle's outputs on each rising edge
  always @(posedge clk) begin
    if (!reset) begin
      if (valid_out) begin
        // Nothing may leave before branch 1 holds a whole frame
        if (writes_no1 < cnn_pkg::FRAME_PIXELS_1) begin
          stop_run($sformatf("Output pixel appeared before branch 1 was full in test %s",
                             test_name[cur_row]));
        end
        if (got_count < GOT_DEPTH) begin
          got_mem[got_count] <= out;
        end
        got_count <= got_count + 1;
      end
      if (frame_done) begin
        frames_done <= frames_done + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("Timeout after %0d cycles, frames still not done", cycle_count));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int frame_start;
    int count;
    clk          = 1'b0;
    reset        = 1'b1;
    valid_in_no1 = 1'b0;
    in_no1       = '0;
    valid_in_no2 = 1'b0;
    in_no2       = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (int row = 0; row < NUM_TESTS; row++) begin
      cur_row <= row;
      frame_start = got_count;
      drive_row(row);
      // frame_done marks the end of this frame's output
      while (frames_done < row + 1) begin
        @(posedge clk);
      end
      count = got_count - frame_start;
      check_count(test_name[row], FRAME_TOTAL, count);
      for (int k = 0; k < FRAME_TOTAL; k++) begin
        check_pixel($sformatf("%s pixel %0d", test_name[row], k),
                    expected_pixel(row, k), got_mem[frame_start + k]);
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: tests/cnn_concat_checker.sv
`timescale 1ns/1ps

module cnn_concat_checker (
  input logic                   clk,
  input logic                   reset,
  input logic                   valid_in_no1,
  input logic                   full_no1,
  input logic                   valid_in_no2,
  input logic                   full_no2,
  input logic                   valid_fifo_no1,
  input logic                   valid_fifo_no2,
  input logic                   valid_out,
  input logic                   frame_done,
  input cnn_pkg::concat_state_t state
);

  //////////////////////////////////////////////////////////////////////
  // Producer rules
  //////////////////////////////////////////////////////////////////////

  // No flow control, so a write on full is lost
  no_write_full_no1: assert property (
    @(posedge clk) disable iff (reset) !(valid_in_no1 && full_no1)
  ) else $error("Write into full branch 1 FIFO");

  no_write_full_no2: assert property (
    @(posedge clk) disable iff (reset) !(valid_in_no2 && full_no2)
  ) else $error("Write into full branch 2 FIFO");

  //////////////////////////////////////////////////////////////////////
  // Drain and output rules
  //////////////////////////////////////////////////////////////////////

  // Sequencer never reads both branches at once
  one_branch_valid: assert property (
    @(posedge clk) disable iff (reset) !(valid_fifo_no1 && valid_fifo_no2)
  ) else $error("Both FIFO read strobes high together");

  frame_done_pulse: assert property (
    @(posedge clk) disable iff (reset) frame_done |=> !frame_done
  ) else $error("frame_done longer than one cycle");

  // Branch 2 data leaves its FIFO only while draining branch 2
  branch_2_in_drain: assert property (
    @(posedge clk) disable iff (reset) valid_fifo_no2 |-> (state == cnn_pkg::DRAIN_2)
  ) else $error("Branch 2 read data outside DRAIN_2");

  valid_low_after_reset: assert property (
    @(posedge clk) reset |=> !valid_out
  ) else $error("valid_out high right after reset");

endmodule

bind cnn_concat_2in cnn_concat_checker inst_checker (
  .clk           (clk),
  .reset         (reset),
  .valid_in_no1  (valid_in_no1),
  .full_no1      (full_no1),
  .valid_in_no2  (valid_in_no2),
  .full_no2      (full_no2),
  .valid_fifo_no1(valid_fifo_no1),
  .valid_fifo_no2(valid_fifo_no2),
  .valid_out     (valid_out),
  .frame_done    (frame_done),
  .state         (inst_sequencer.state)
);

// File: hdl/cnn_concat_2in.sv
`timescale 1ns/1ps

module cnn_concat_2in (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid_in_no1,
  input  cnn_pkg::pixel_t in_no1,
  input  logic            valid_in_no2,
  input  cnn_pkg::pixel_t in_no2,
  output cnn_pkg::pixel_t out,
  output logic            valid_out,
  output logic            frame_done
);

  //////////////////////////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////////////////////////

  // Read levels from the sequencer
  logic read_no1;
  logic read_no2;

  // Branch 1 FIFO outputs
  cnn_pkg::pixel_t data_fifo_no1;
  logic            valid_fifo_no1;
  logic            full_no1;
  logic            empty_no1;

  // Branch 2 FIFO outputs
  cnn_pkg::pixel_t data_fifo_no2;
  logic            valid_fifo_no2;
  logic            full_no2;
  logic            empty_no2;

  //////////////////////////////////////////////////////////////////////
  // Branch 1 FIFO
  //////////////////////////////////////////////////////////////////////

  // One full branch 1 frame
  cnn_fifo_other #(
    .DATA_DEPTH   (cnn_pkg::FRAME_PIXELS_1),
    .POINTER_WIDTH(cnn_pkg::PTR_WIDTH_1)
  ) inst_fifo_no1 (
    .clk      (clk),
    .reset    (reset),
    .write    (valid_in_no1),
    .read     (read_no1),
    .data_in  (in_no1),
    .data_out (data_fifo_no1),
    .valid_out(valid_fifo_no1),
    .empty    (empty_no1),
    .full     (full_no1)
  );

  //////////////////////////////////////////////////////////////////////
  // Branch 2 FIFO
  //////////////////////////////////////////////////////////////////////

  // One full branch 2 frame
  cnn_fifo_other #(
    .DATA_DEPTH   (cnn_pkg::FRAME_PIXELS_2),
    .POINTER_WIDTH(cnn_pkg::PTR_WIDTH_2)
  ) inst_fifo_no2 (
    .clk      (clk),
    .reset    (reset),
    .write    (valid_in_no2),
    .read     (read_no2),
    .data_in  (in_no2),
    .data_out (data_fifo_no2),
    .valid_out(valid_fifo_no2),
    .empty    (empty_no2),
    .full     (full_no2)
  );

  //////////////////////////////////////////////////////////////////////
  // Drain order
  //////////////////////////////////////////////////////////////////////

  // Branch 1 whole, then branch 2 once full
  concat_sequencer inst_sequencer (
    .clk       (clk),
    .reset     (reset),
    .full_no1  (full_no1),
    .empty_no1 (empty_no1),
    .full_no2  (full_no2),
    .empty_no2 (empty_no2),
    .read_no1  (read_no1),
    .read_no2  (read_no2),
    .frame_done(frame_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  // Strobe follows either branch, one cycle behind the FIFO
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_fifo_no1 | valid_fifo_no2;
    end
  end

  // Pixel select, branch 1 first
  // Idle cycles keep the last pixel
  always_ff @(posedge clk) begin
    if (valid_fifo_no1) begin
      out <= data_fifo_no1;
    end else if (valid_fifo_no2) begin
      out <= data_fifo_no2;
    end
  end

endmodule

// File: hdl/concat_sequencer.sv
`timescale 1ns/1ps

module concat_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic full_no1,
  input  logic empty_no1,
  input  logic full_no2,
  input  logic empty_no2,
  output logic read_no1,
  output logic read_no2,
  output logic frame_done
);

  //////////////////////////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////////////////////////

  cnn_pkg::concat_state_t state;
  cnn_pkg::concat_state_t next_state;

  // End of frame, branch 2 ran dry while draining
  logic last_drained;

  assign last_drained = (state == cnn_pkg::DRAIN_2) && empty_no2;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cnn_pkg::FILL;
    end else begin
      state <= next_state;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state = state;
    case (state)
      // Branch 1 always goes out first
      cnn_pkg::FILL: begin
        if (full_no1) begin
          next_state = cnn_pkg::DRAIN_1;
        end
      end

      // Read until branch 1 runs empty
      cnn_pkg::DRAIN_1: begin
        if (empty_no1) begin
          // Skip the wait if branch 2 is ready
          if (full_no2) begin
            next_state = cnn_pkg::DRAIN_2;
          end else begin
            next_state = cnn_pkg::WAIT_2;
          end
        end
      end

      // Branch 2 may still be arriving
      cnn_pkg::WAIT_2: begin
        if (full_no2) begin
          next_state = cnn_pkg::DRAIN_2;
        end
      end

      // Rearm for the next frame once empty
      cnn_pkg::DRAIN_2: begin
        if (empty_no2) begin
          next_state = cnn_pkg::FILL;
        end
      end

      default: begin
        next_state = cnn_pkg::FILL;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registered outputs
  //////////////////////////////////////////////////////////////////////

  // Read levels follow the state they belong to
  // Both are decoded from next_state so they line up with it
  always_ff @(posedge clk) begin
    if (reset) begin
      read_no1 <= 1'b0;
      read_no2 <= 1'b0;
    end else begin
      read_no1 <= (next_state == cnn_pkg::DRAIN_1);
      read_no2 <= (next_state == cnn_pkg::DRAIN_2);
    end
  end

  // Single pulse on the return to FILL
  // Lands with the last branch 2 pixel at the top output
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_done <= 1'b0;
    end else begin
      frame_done <= last_drained;
    end
  end

endmodule

// File: hdl/cnn_fifo_other.sv
`timescale 1ns/1ps

module cnn_fifo_other #(
  parameter int DATA_DEPTH    = 16,
  parameter int POINTER_WIDTH = 5
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            write,
  input  logic            read,
  input  cnn_pkg::pixel_t data_in,
  output cnn_pkg::pixel_t data_out,
  output logic            valid_out,
  output logic            empty,
  output logic            full
);

  //////////////////////////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////////////////////////

  // Circular buffer, one frame deep
  cnn_pkg::pixel_t mem [DATA_DEPTH];

  // Top bit is the lap flag, the rest is the address
  logic [POINTER_WIDTH-1:0] wr_ptr;
  logic [POINTER_WIDTH-1:0] rd_ptr;

  // Accepted operations only
  logic do_write;
  logic do_read;

  // Step a pointer, wrap at DATA_DEPTH and flip the lap bit
  // Depth need not be a power of two
  function automatic logic [POINTER_WIDTH-1:0] next_ptr(
    input logic [POINTER_WIDTH-1:0] ptr
  );
    logic [POINTER_WIDTH-1:0] nxt;
    if (ptr[POINTER_WIDTH-2:0] == (POINTER_WIDTH-1)'(DATA_DEPTH - 1)) begin
      nxt = {~ptr[POINTER_WIDTH-1], {(POINTER_WIDTH-1){1'b0}}};
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Flags
  //////////////////////////////////////////////////////////////////////

  // Same address and same lap, nothing stored
  assign empty = (wr_ptr == rd_ptr);

  // Same address on different laps, every slot used
  assign full = (wr_ptr[POINTER_WIDTH-1] != rd_ptr[POINTER_WIDTH-1]) &&
                (wr_ptr[POINTER_WIDTH-2:0] == rd_ptr[POINTER_WIDTH-2:0]);

  // Drop writes on full, reads on empty
  assign do_write = write & ~full;
  assign do_read  = read & ~empty;

  //////////////////////////////////////////////////////////////////////
  // Pointer update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  // Memory write
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr[POINTER_WIDTH-2:0]] <= data_in;
    end
  end

  // Registered read data, held between reads
  always_ff @(posedge clk) begin
    if (do_read) begin
      data_out <= mem[rd_ptr[POINTER_WIDTH-2:0]];
    end
  end

  // One-cycle strobe alongside the read data
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= do_read;
    end
  end

endmodule

// File: hdl/cnn_pkg.sv
////////////////////////////////////////////////////////////////////////
// Shared definitions for the feature-map concat stage
////////////////////////////////////////////////////////////////////////

package cnn_pkg;

  // Pixel width, one feature-map element
  localparam int DATA_WIDTH = 16;

  // Branch frame lengths, also the FIFO depths
  localparam int FRAME_PIXELS_1 = 16;
  localparam int FRAME_PIXELS_2 = 12;

  // Pointer widths, address plus one lap bit for full detection
  localparam int PTR_WIDTH_1 = $clog2(FRAME_PIXELS_1) + 1;
  localparam int PTR_WIDTH_2 = $clog2(FRAME_PIXELS_2) + 1;

  // One pixel on a port
  typedef logic [DATA_WIDTH-1:0] pixel_t;

  // Sequencer states
  typedef enum logic [1:0] {
    // Waiting for branch 1 to fill
    FILL    = 2'd0,
    // Reading branch 1
    DRAIN_1 = 2'd1,
    // Branch 1 done, branch 2 not full yet
    WAIT_2  = 2'd2,
    // Reading branch 2
    DRAIN_2 = 2'd3
  } concat_state_t;

endpackage
